/* Makefile */
VERILATOR  ?= verilator
TOP        ?= ex_stage_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
FAIL_TEXT  ?= TESTS FAILED
PASS_TEXT  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu/ex_alu.sv */
// Integer ALU

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_alu
(
    input  ex_pkg::ex_op_e       op,
    input  logic [`EX_XLEN-1:0]  a,
    input  logic [`EX_XLEN-1:0]  b,
    input  logic [`EX_XLEN-1:0]  pc,
    output logic [`EX_XLEN-1:0]  result,
    output logic                 writes_rd,
    output logic                 is_load
);

    function automatic logic [`EX_XLEN-1:0] sext_word(
        input logic [`EX_WORD_WIDTH-1:0] w
    );
        return {{(`EX_XLEN-`EX_WORD_WIDTH){w[`EX_WORD_WIDTH-1]}}, w};
    endfunction

    logic [`EX_SHAMT_WIDTH-1:0]  shamt;
    logic [`EX_SHAMTW_WIDTH-1:0] shamtw;
    logic [`EX_WORD_WIDTH-1:0]   a_word;
    logic [`EX_WORD_WIDTH-1:0]   b_word;
    logic [`EX_XLEN-1:0]         sum;
    logic [`EX_XLEN-1:0]         link;

    assign shamt  = b[`EX_SHAMT_WIDTH-1:0];
    assign shamtw = b[`EX_SHAMTW_WIDTH-1:0];
    assign a_word = a[`EX_WORD_WIDTH-1:0];
    assign b_word = b[`EX_WORD_WIDTH-1:0];
    assign sum    = a + b;
    assign link   = pc + `EX_XLEN'(`EX_INSN_BYTES);

    always_comb
    begin
        result    = '0;
        writes_rd = 1'b1;
        is_load   = 1'b0;
        case (op)
            ex_pkg::OP_ADD:
                result = sum;
            ex_pkg::OP_SUB:
                result = a - b;
            ex_pkg::OP_SLL:
                result = a << shamt;
            ex_pkg::OP_SLT:
                result = `EX_XLEN'($signed(a) < $signed(b));
            ex_pkg::OP_SLTU:
                result = `EX_XLEN'(a < b);
            ex_pkg::OP_XOR:
                result = a ^ b;
            ex_pkg::OP_SRL:
                result = a >> shamt;
            ex_pkg::OP_SRA:
                result = $signed(a) >>> shamt;
            ex_pkg::OP_OR:
                result = a | b;
            ex_pkg::OP_AND:
                result = a & b;
            // W forms compute on the low word and sign-extend bit 31
            ex_pkg::OP_ADDW:
                result = sext_word(a_word + b_word);
            ex_pkg::OP_SUBW:
                result = sext_word(a_word - b_word);
            ex_pkg::OP_SLLW:
                result = sext_word(a_word << shamtw);
            ex_pkg::OP_SRLW:
                result = sext_word(a_word >> shamtw);
            ex_pkg::OP_SRAW:
                result = sext_word($signed(a_word) >>> shamtw);
            ex_pkg::OP_LUI:
                result = b;
            ex_pkg::OP_AUIPC:
                result = pc + b;
            ex_pkg::OP_LOAD:
            begin
                result    = sum;
                writes_rd = 1'b0;
                is_load   = 1'b1;
            end
            ex_pkg::OP_STORE:
            begin
                result    = sum;
                writes_rd = 1'b0;
            end
            ex_pkg::OP_JAL, ex_pkg::OP_JALR:
                result = link;
            default:
                // Branches, NOP and unknown codes leave rd alone
                writes_rd = 1'b0;
        endcase
    end

endmodule

/* common/ex_defines.svh */
// Execute stage widths and constants

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Integer register width
`define EX_XLEN 64

// Operand width of the W-form operations
`define EX_WORD_WIDTH 32

// Architectural register number
`define EX_REGNO_WIDTH 5

// Shift amount for full width shifts
`define EX_SHAMT_WIDTH 6

// Shift amount for W-form shifts
`define EX_SHAMTW_WIDTH 5

// Link address is the next sequential instruction
`define EX_INSN_BYTES 4

`endif

/* common/ex_pkg.sv */
// Execute stage types

`include "ex_defines.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        OP_LUI,
        OP_AUIPC,
        OP_LOAD,
        OP_STORE,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR
    } ex_op_e;

    // One instruction from decode
    typedef struct packed {
        ex_op_e                     op;
        logic                       use_imm;
        logic [`EX_REGNO_WIDTH-1:0] rd;
        logic [`EX_REGNO_WIDTH-1:0] rs1;
        logic [`EX_REGNO_WIDTH-1:0] rs2;
        logic [`EX_XLEN-1:0]        rs1_value;
        logic [`EX_XLEN-1:0]        rs2_value;
        logic [`EX_XLEN-1:0]        imm;
        logic [`EX_XLEN-1:0]        pc;
    } ex_issue_t;

    // What a later stage is about to write back
    typedef struct packed {
        logic [`EX_REGNO_WIDTH-1:0] rd;
        logic                       writes_rd;
        logic                       is_load;
        logic [`EX_XLEN-1:0]        data;
    } ex_fwd_t;

    // ALU stage register
    typedef struct packed {
        logic                       valid;
        logic [`EX_XLEN-1:0]        result;
        logic [`EX_XLEN-1:0]        store_data;
        logic [`EX_REGNO_WIDTH-1:0] rd;
        logic                       writes_rd;
        logic                       is_load;
        logic                       branch_taken;
        logic [`EX_XLEN-1:0]        target;
    } ex_result_t;

endpackage

/* filelist.f */
+incdir+common
common/ex_pkg.sv
verilog/ex_forward_unit.sv
alu/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_stage.sv
verif/ex_stage_asserts.sv
verif/ex_stage_tb.sv

/* verif/ex_stage_asserts.sv */
// Execute stage assertions

`timescale 1ns/1ns

module ex_stage_asserts
(
    input logic               clk,
    input logic               reset,
    input logic               issue_ready,
    input logic               flush,
    input ex_pkg::ex_result_t result
);

    // Register is cleared by every reset edge
    reset_clears_result: assert property (
        @(posedge clk) reset |=> !result.valid
    ) else $error("valid result in the cycle after reset");

    // A held instruction leaves a bubble
    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (reset) !issue_ready |=> !result.valid
    ) else $error("valid result after a cycle with issue_ready low");

    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (reset) flush |=> !result.valid
    ) else $error("valid result after a flush");

endmodule

bind ex_stage ex_stage_asserts asserts_i (
    .clk         (clk),
    .reset       (reset),
    .issue_ready (issue_ready),
    .flush       (flush),
    .result      (result)
);

/* verif/ex_stage_tb.sv */
// Execute stage testbench

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_stage_tb;

    logic               clk;
    logic               reset;
    logic               issue_valid;
    ex_pkg::ex_issue_t  issue;
    logic               issue_ready;
    ex_pkg::ex_fwd_t    fwd_mm;
    ex_pkg::ex_fwd_t    fwd_wb;
    logic               flush;
    ex_pkg::ex_result_t result;
    int                 seed;
    int                 mismatches;
    int                 timeouts;

    ex_stage dut_i (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .fwd_mm      (fwd_mm),
        .fwd_wb      (fwd_wb),
        .flush       (flush),
        .result      (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [`EX_XLEN-1:0] sign_extend_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // Own register first, then memory stage, then write-back
    function automatic logic [`EX_XLEN-1:0] operand_value(
        input logic [4:0]          src,
        input logic [`EX_XLEN-1:0] rf,
        input ex_pkg::ex_result_t  prev,
        input ex_pkg::ex_fwd_t     mm,
        input ex_pkg::ex_fwd_t     wb
    );
        if (src != '0 && prev.valid && prev.writes_rd && prev.rd == src)
            return prev.result;
        if (src != '0 && (mm.writes_rd || mm.is_load) && mm.rd == src)
            return mm.data;
        if (src != '0 && wb.writes_rd && wb.rd == src)
            return wb.data;
        return rf;
    endfunction

    function automatic ex_pkg::ex_result_t model_execute(
        input  ex_pkg::ex_issue_t  insn,
        input  ex_pkg::ex_result_t prev,
        input  ex_pkg::ex_fwd_t    mm,
        input  ex_pkg::ex_fwd_t    wb,
        output logic               hazard
    );
        ex_pkg::ex_result_t  r;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] s2;
        logic [`EX_XLEN-1:0] b;
        logic                uses1;
        logic                uses2;
        r  = '0;
        a  = operand_value(insn.rs1, insn.rs1_value, prev, mm, wb);
        s2 = operand_value(insn.rs2, insn.rs2_value, prev, mm, wb);
        b  = insn.use_imm ? insn.imm : s2;
        uses1 = !(insn.op inside {ex_pkg::OP_NOP, ex_pkg::OP_LUI, ex_pkg::OP_AUIPC,
                                  ex_pkg::OP_JAL});
        uses2 = (insn.op inside {[ex_pkg::OP_STORE : ex_pkg::OP_BGEU]})
                || (!insn.use_imm && insn.op inside {[ex_pkg::OP_ADD : ex_pkg::OP_SRAW]});
        hazard = prev.valid && prev.is_load && prev.rd != '0
                 && ((uses1 && insn.rs1 == prev.rd) || (uses2 && insn.rs2 == prev.rd));
        if (hazard || !(insn.op inside {[ex_pkg::OP_ADD : ex_pkg::OP_JALR]}))
            return r;
        r.valid      = 1'b1;
        r.rd         = insn.rd;
        r.store_data = s2;
        r.is_load    = (insn.op == ex_pkg::OP_LOAD);
        r.writes_rd  = insn.op inside {[ex_pkg::OP_ADD : ex_pkg::OP_AUIPC],
                                       ex_pkg::OP_JAL, ex_pkg::OP_JALR};
        case (insn.op)
            ex_pkg::OP_ADD, ex_pkg::OP_LOAD, ex_pkg::OP_STORE: r.result = a + b;
            ex_pkg::OP_SUB:   r.result = a - b;
            ex_pkg::OP_SLL:   r.result = a << b[5:0];
            ex_pkg::OP_SLT:   r.result = {63'd0, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU:  r.result = {63'd0, a < b};
            ex_pkg::OP_XOR:   r.result = a ^ b;
            ex_pkg::OP_SRL:   r.result = a >> b[5:0];
            ex_pkg::OP_SRA:   r.result = $signed(a) >>> b[5:0];
            ex_pkg::OP_OR:    r.result = a | b;
            ex_pkg::OP_AND:   r.result = a & b;
            ex_pkg::OP_ADDW:  r.result = sign_extend_word(a[31:0] + b[31:0]);
            ex_pkg::OP_SUBW:  r.result = sign_extend_word(a[31:0] - b[31:0]);
            ex_pkg::OP_SLLW:  r.result = sign_extend_word(a[31:0] << b[4:0]);
            ex_pkg::OP_SRLW:  r.result = sign_extend_word(a[31:0] >> b[4:0]);
            ex_pkg::OP_SRAW:  r.result = sign_extend_word($signed(a[31:0]) >>> b[4:0]);
            ex_pkg::OP_LUI:   r.result = b;
            ex_pkg::OP_AUIPC: r.result = insn.pc + b;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: r.result = insn.pc + `EX_XLEN'(`EX_INSN_BYTES);
            default: ;
        endcase
        case (insn.op)
            ex_pkg::OP_BEQ:  r.branch_taken = (a == s2);
            ex_pkg::OP_BNE:  r.branch_taken = (a != s2);
            ex_pkg::OP_BLT:  r.branch_taken = ($signed(a) < $signed(s2));
            ex_pkg::OP_BGE:  r.branch_taken = ($signed(a) >= $signed(s2));
            ex_pkg::OP_BLTU: r.branch_taken = (a < s2);
            ex_pkg::OP_BGEU: r.branch_taken = (a >= s2);
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: r.branch_taken = 1'b1;
            default: r.branch_taken = 1'b0;
        endcase
        if (r.branch_taken)
            r.target = (insn.op == ex_pkg::OP_JALR) ? ((a + insn.imm) & ~64'd1)
                                                     : insn.pc + insn.imm;
        return r;
    endfunction

    // Checks the stage register and issue_ready in the middle of each cycle
    initial
    begin : compare
        ex_pkg::ex_result_t expected;
        ex_pkg::ex_result_t computed;
        logic               hazard;
        expected = '0;
        // First edge loads the register from reset
        @(posedge clk);
        forever
        begin
            @(negedge clk);
            if (result !== expected)
            begin
                mismatches++;
                $display("FAILED at %0t ns: result %h, expected %h", $time, result, expected);
            end
            computed = model_execute(issue, expected, fwd_mm, fwd_wb, hazard);
            if (issue_ready !== !hazard)
            begin
                mismatches++;
                $display("FAILED at %0t ns: issue_ready %b, expected %b",
                         $time, issue_ready, !hazard);
            end
            if (reset || flush || !issue_valid)
                expected = '0;
            else
                expected = computed;
        end
    end

    function automatic logic [`EX_XLEN-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic ex_pkg::ex_issue_t build_issue(
        input ex_pkg::ex_op_e      op,
        input logic                use_imm,
        input logic [4:0]          rd,
        input logic [4:0]          rs1,
        input logic [4:0]          rs2,
        input logic [`EX_XLEN-1:0] v1,
        input logic [`EX_XLEN-1:0] v2,
        input logic [`EX_XLEN-1:0] imm
    );
        ex_pkg::ex_issue_t t;
        t.op        = op;
        t.use_imm   = use_imm;
        t.rd        = rd;
        t.rs1       = rs1;
        t.rs2       = rs2;
        t.rs1_value = v1;
        t.rs2_value = v2;
        t.imm       = imm;
        t.pc        = {32'd0, $random(seed)} & ~64'd3;
        return t;
    endfunction

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!issue_ready && waited < 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready)
        begin
            timeouts++;
            $display("Timeout at %0t ns: issue_ready stayed low for %0d cycles", $time, waited);
        end
        @(posedge clk);
        #5;
    endtask

    task automatic send_insn(input ex_pkg::ex_issue_t insn);
        issue_valid = 1'b1;
        issue       = insn;
        wait_ready();
        issue_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        issue_valid = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        idle_cycles(5);
        reset = 1'b0;
    endtask

    // Dependent op right behind a load that then shows up in fwd_mm
    task automatic run_load_use(
        input ex_pkg::ex_issue_t   load,
        input ex_pkg::ex_issue_t   dependent,
        input logic [`EX_XLEN-1:0] load_data
    );
        send_insn(load);
        issue_valid = 1'b1;
        issue       = dependent;
        @(posedge clk);
        #5;
        fwd_mm = '{rd: load.rd, writes_rd: 1'b0, is_load: 1'b1, data: load_data};
        wait_ready();
        issue_valid = 1'b0;
        fwd_mm      = '0;
    endtask

    initial
    begin : stimulus
        ex_pkg::ex_op_e      op;
        logic [`EX_XLEN-1:0] lhs;
        logic [`EX_XLEN-1:0] rhs;
        int                  i;
        int                  j;
        seed        = 57315;
        mismatches  = 0;
        timeouts    = 0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        fwd_mm      = '0;
        fwd_wb      = '0;
        flush       = 1'b0;
        apply_reset();

        // Sources 1 to 15 and destinations 16 to 31 keep these independent
        for (i = 0; i < 60; i++)
        begin
            op = ex_pkg::ex_op_e'(6'(1 + {$random(seed)} % 17));
            send_insn(build_issue(op,
                1'($random(seed)) || op inside {ex_pkg::OP_LUI, ex_pkg::OP_AUIPC},
                5'(16 + {$random(seed)} % 16), 5'(1 + {$random(seed)} % 15),
                5'(1 + {$random(seed)} % 15), random_word(), random_word(), random_word()));
        end

        // Equal, signed less and signed greater operands for every branch
        for (i = 0; i < 6; i++)
            for (j = 0; j < 3; j++)
            begin
                lhs = (j == 1) ? 64'hFFFF_FFFF_FFFF_FFFB : 64'd7;
                rhs = (j == 2) ? 64'hFFFF_FFFF_FFFF_FFFB : 64'd7;
                op  = ex_pkg::ex_op_e'(6'(ex_pkg::OP_BEQ + i));
                send_insn(build_issue(op, 1'b0, 5'd0, 5'd1, 5'd2, lhs, rhs, random_word()));
            end
        send_insn(build_issue(ex_pkg::OP_JAL, 1'b1, 5'd20, 5'd0, 5'd0, 0, 0, 64'h7FC));
        send_insn(build_issue(ex_pkg::OP_JALR, 1'b1, 5'd21, 5'd1, 5'd0, 64'h1001, 0, 64'h20));

        // Own result beats both later stages
        send_insn(build_issue(ex_pkg::OP_ADD, 1'b0, 5'd3, 5'd1, 5'd2, 64'h30, 64'h12, 0));
        fwd_mm = '{rd: 5'd3, writes_rd: 1'b1, is_load: 1'b0, data: 64'h1111};
        fwd_wb = '{rd: 5'd3, writes_rd: 1'b1, is_load: 1'b0, data: 64'h2222};
        send_insn(build_issue(ex_pkg::OP_ADD, 1'b0, 5'd4, 5'd3, 5'd3, 64'h5, 64'h5, 0));
        fwd_mm = '{rd: 5'd7, writes_rd: 1'b1, is_load: 1'b0, data: 64'h3333};
        fwd_wb = '{rd: 5'd7, writes_rd: 1'b1, is_load: 1'b0, data: 64'h4444};
        send_insn(build_issue(ex_pkg::OP_SUB, 1'b0, 5'd5, 5'd7, 5'd2, 64'h9, 64'h3, 0));
        fwd_mm = '0;
        send_insn(build_issue(ex_pkg::OP_ADD, 1'b0, 5'd6, 5'd7, 5'd2, 64'h9, 64'h3, 0));
        // Register 0 is never forwarded
        send_insn(build_issue(ex_pkg::OP_ADD, 1'b1, 5'd0, 5'd1, 5'd0, 64'h55, 0, 64'h1));
        fwd_mm = '{rd: 5'd0, writes_rd: 1'b1, is_load: 1'b0, data: 64'h5555};
        fwd_wb = '{rd: 5'd0, writes_rd: 1'b1, is_load: 1'b0, data: 64'h6666};
        send_insn(build_issue(ex_pkg::OP_OR, 1'b0, 5'd8, 5'd0, 5'd0, 0, 0, 0));
        fwd_mm = '{rd: 5'd9, writes_rd: 1'b1, is_load: 1'b0, data: 64'hABCD};
        fwd_wb = '0;
        send_insn(build_issue(ex_pkg::OP_STORE, 1'b1, 5'd0, 5'd2, 5'd9, 64'h100, 64'h1, 64'h10));
        fwd_mm = '0;

        run_load_use(build_issue(ex_pkg::OP_LOAD, 1'b1, 5'd10, 5'd2, 5'd0, 64'h8000, 0, 64'h40),
                     build_issue(ex_pkg::OP_ADD, 1'b0, 5'd11, 5'd10, 5'd2, 0, 64'h7, 0),
                     64'hCAFE_0000);
        run_load_use(build_issue(ex_pkg::OP_LOAD, 1'b1, 5'd12, 5'd2, 5'd0, 64'h9000, 0, 64'h8),
                     build_issue(ex_pkg::OP_STORE, 1'b1, 5'd0, 5'd1, 5'd12, 64'h200, 0, 64'h4),
                     64'hBEEF_1234);

        // Flush kills the entry in the stage and the one being presented
        send_insn(build_issue(ex_pkg::OP_ADD, 1'b1, 5'd13, 5'd1, 5'd0, 64'h10, 0, 64'h1));
        issue_valid = 1'b1;
        issue       = build_issue(ex_pkg::OP_ADD, 1'b1, 5'd14, 5'd1, 5'd0, 64'h20, 0, 64'h2);
        flush       = 1'b1;
        @(posedge clk);
        #5;
        flush       = 1'b0;
        idle_cycles(2);
        send_insn(build_issue(ex_pkg::OP_XOR, 1'b1, 5'd15, 5'd1, 5'd0, 64'hF0, 0, 64'hFF));
        apply_reset();
        idle_cycles(3);

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/ex_branch_unit.sv */
// Branch and jump resolution

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_branch_unit
(
    input  ex_pkg::ex_op_e       op,
    input  logic [`EX_XLEN-1:0]  a,
    input  logic [`EX_XLEN-1:0]  b,
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_XLEN-1:0]  imm,
    output logic                 taken,
    output logic [`EX_XLEN-1:0]  target
);

    logic                eq;
    logic                lt;
    logic                ltu;
    logic [`EX_XLEN-1:0] jalr_sum;

    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    assign jalr_sum = a + imm;

    always_comb
    begin
        case (op)
            ex_pkg::OP_BEQ:  taken = eq;
            ex_pkg::OP_BNE:  taken = !eq;
            ex_pkg::OP_BLT:  taken = lt;
            ex_pkg::OP_BGE:  taken = !lt;
            ex_pkg::OP_BLTU: taken = ltu;
            ex_pkg::OP_BGEU: taken = !ltu;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR:
                taken = 1'b1;
            default:
                taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (!taken)
            target = '0;
        else if (op == ex_pkg::OP_JALR)
            // Bit 0 of an indirect target is always dropped
            target = {jalr_sum[`EX_XLEN-1:1], 1'b0};
        else
            target = pc + imm;
    end

endmodule

/* verilog/ex_forward_unit.sv */
// Operand forwarding and load-use detection

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_forward_unit
(
    input  ex_pkg::ex_issue_t    issue,
    input  ex_pkg::ex_fwd_t      ex_fwd,
    input  ex_pkg::ex_fwd_t      fwd_mm,
    input  ex_pkg::ex_fwd_t      fwd_wb,
    output logic [`EX_XLEN-1:0]  rs1_data,
    output logic [`EX_XLEN-1:0]  rs2_data,
    output logic                 load_use
);

    // Youngest producer wins, register 0 is never forwarded
    function automatic logic [`EX_XLEN-1:0] pick_operand(
        input logic [`EX_REGNO_WIDTH-1:0] src,
        input logic [`EX_XLEN-1:0]        rf_value,
        input ex_pkg::ex_fwd_t            ex_src,
        input ex_pkg::ex_fwd_t            mm_src,
        input ex_pkg::ex_fwd_t            wb_src
    );
        logic nonzero;
        nonzero = (src != '0);
        if (nonzero && ex_src.writes_rd && ex_src.rd == src)
            return ex_src.data;
        else if (nonzero && (mm_src.writes_rd || mm_src.is_load) && mm_src.rd == src)
            return mm_src.data;
        else if (nonzero && wb_src.writes_rd && wb_src.rd == src)
            return wb_src.data;
        else
            return rf_value;
    endfunction

    logic reads_rs1;
    logic reads_rs2;
    logic rs1_hit;
    logic rs2_hit;

    always_comb
    begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b0;
        case (issue.op)
            ex_pkg::OP_NOP, ex_pkg::OP_LUI, ex_pkg::OP_AUIPC, ex_pkg::OP_JAL:
                reads_rs1 = 1'b0;
            ex_pkg::OP_STORE, ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT,
            ex_pkg::OP_BGE, ex_pkg::OP_BLTU, ex_pkg::OP_BGEU:
                reads_rs2 = 1'b1;
            ex_pkg::OP_LOAD, ex_pkg::OP_JALR:
                reads_rs2 = 1'b0;
            default:
                // Register-register forms of the ALU ops
                reads_rs2 = !issue.use_imm;
        endcase
    end

    assign rs1_data = pick_operand(issue.rs1, issue.rs1_value, ex_fwd, fwd_mm, fwd_wb);
    assign rs2_data = pick_operand(issue.rs2, issue.rs2_value, ex_fwd, fwd_mm, fwd_wb);

    // Load address is in the stage register, its data is not ready yet
    assign rs1_hit = reads_rs1 && issue.rs1 == ex_fwd.rd;
    assign rs2_hit = reads_rs2 && issue.rs2 == ex_fwd.rd;
    assign load_use = ex_fwd.is_load && ex_fwd.rd != '0 && (rs1_hit || rs2_hit);

endmodule

/* verilog/ex_stage.sv */
// RV64 integer execute stage

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_stage
(
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  ex_pkg::ex_issue_t   issue,
    output logic                issue_ready,
    input  ex_pkg::ex_fwd_t     fwd_mm,
    input  ex_pkg::ex_fwd_t     fwd_wb,
    input  logic                flush,
    output ex_pkg::ex_result_t  result
);

    ex_pkg::ex_result_t  result_q;
    ex_pkg::ex_result_t  exec;
    ex_pkg::ex_fwd_t     ex_fwd;
    logic                stalled;
    logic                load_use;
    logic                op_known;
    logic                accept;
    logic [`EX_XLEN-1:0] rs1_data;
    logic [`EX_XLEN-1:0] rs2_data;
    logic [`EX_XLEN-1:0] alu_b;
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_writes_rd;
    logic                alu_is_load;
    logic                taken;
    logic [`EX_XLEN-1:0] target;

    // Own register seen as the youngest forwarding source
    assign ex_fwd.rd        = result_q.rd;
    assign ex_fwd.writes_rd = result_q.valid && result_q.writes_rd;
    assign ex_fwd.is_load   = result_q.valid && result_q.is_load;
    assign ex_fwd.data      = result_q.result;

    ex_forward_unit u_forward (
        .issue    (issue),
        .ex_fwd   (ex_fwd),
        .fwd_mm   (fwd_mm),
        .fwd_wb   (fwd_wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .load_use (load_use)
    );

    assign alu_b = issue.use_imm ? issue.imm : rs2_data;

    ex_alu u_alu (
        .op        (issue.op),
        .a         (rs1_data),
        .b         (alu_b),
        .pc        (issue.pc),
        .result    (alu_result),
        .writes_rd (alu_writes_rd),
        .is_load   (alu_is_load)
    );

    ex_branch_unit u_branch (
        .op     (issue.op),
        .a      (rs1_data),
        .b      (rs2_data),
        .pc     (issue.pc),
        .imm    (issue.imm),
        .taken  (taken),
        .target (target)
    );

    // The stall never lasts past the cycle after it
    assign issue_ready = !load_use || stalled;

    assign op_known = issue.op inside {[ex_pkg::OP_ADD : ex_pkg::OP_JALR]};
    assign accept   = issue_valid && issue_ready && op_known;

    assign exec.valid        = 1'b1;
    assign exec.result       = alu_result;
    assign exec.store_data   = rs2_data;
    assign exec.rd           = issue.rd;
    assign exec.writes_rd    = alu_writes_rd;
    assign exec.is_load      = alu_is_load;
    assign exec.branch_taken = taken;
    assign exec.target       = target;

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            result_q <= '0;
            stalled  <= 1'b0;
        end
        else
        begin
            stalled <= issue_valid && !issue_ready;
            // Stall, idle and unknown opcodes all leave a bubble
            result_q <= accept ? exec : '0;
        end
    end

    assign result = result_q;

endmodule
